// File: verilog/telemetry_pkg.sv
// Telemetry and debug-line framing definitions.
// Shared by the snapshot, the hex line formatter and the top level.
// A frame is one ASCII line per channel: 2 index digits, 4 value digits, LF, CR.

package telemetry_pkg;

    localparam int num_channels   = 8;
    localparam int chan_idx_w     = 3;
    localparam int word_w         = 16;
    localparam int chars_per_line = 8;
    localparam int char_idx_w     = 3;

    // character positions within a line
    localparam logic [char_idx_w-1:0] char_pos_idx_hi = 3'd0;
    localparam logic [char_idx_w-1:0] char_pos_idx_lo = 3'd1;
    localparam logic [char_idx_w-1:0] char_pos_val    = 3'd2;  // first of four value digits
    localparam logic [char_idx_w-1:0] char_pos_lf     = 3'd6;
    localparam logic [char_idx_w-1:0] char_pos_cr     = 3'd7;

    localparam logic [7:0] ascii_zero    = 8'h30;
    localparam logic [7:0] ascii_upper_a = 8'h41;
    localparam logic [7:0] ascii_lf      = 8'h0a;
    localparam logic [7:0] ascii_cr      = 8'h0d;

    // all channels side by side, channel 0 in the low word
    typedef logic [num_channels-1:0][word_w-1:0] chan_bus_t;

    typedef enum logic [2:0] {
        FMT_INIT_LCR,
        FMT_IDLE,
        FMT_CAPTURE,
        FMT_WAIT_EMPTY,
        FMT_WRITE,
        FMT_NEXT,
        FMT_DONE
    } fmt_state_e;

endpackage

// File: verilog/uart_pkg.sv
// Register map and line control encoding of the transmit-only UART.
// The formatter writes these registers; the transmit engine decodes them.

package uart_pkg;

    typedef enum logic [1:0] {
        REG_THR = 2'd0,  // transmit holding register
        REG_LCR = 2'd3   // line control
    } uart_reg_e;

    // line control fields
    localparam int         lcr_tx_en_bit = 7;
    localparam logic [1:0] lcr_wlen_8    = 2'b11;  // 8 data bits
    localparam logic       lcr_stop_1    = 1'b0;   // 1 stop bit

    // written once after reset
    localparam logic [7:0] lcr_init =
        (8'h01 << lcr_tx_en_bit) | {5'b00000, lcr_stop_1, lcr_wlen_8};

    // bit period in clocks, kept short for simulation
    localparam int default_clks_per_bit = 8;

endpackage

// File: verilog/telemetry_snapshot.sv
// Channel snapshot register for the telemetry debug port.
// capture_i freezes every channel at once so a frame reports one instant;
// the formatter then reads the held words one at a time through chan_sel_i.

`timescale 1ns/100ps

module telemetry_snapshot (
    input  logic                                clk,
    input  logic                                resetn,
    input  logic                                capture_i,
    input  telemetry_pkg::chan_bus_t            chan_data_i,
    input  logic [telemetry_pkg::chan_idx_w-1:0] chan_sel_i,
    output logic [telemetry_pkg::word_w-1:0]     chan_word_o
);

    import telemetry_pkg::*;

    chan_bus_t held_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            held_q <= '0;
        end else if (capture_i) begin
            held_q <= chan_data_i;  // all channels on the same edge
        end
    end

    // read mux, combinational
    assign chan_word_o = held_q[chan_sel_i];

endmodule

// File: verilog/hex_line_formatter.sv
// Frame sequencer of the telemetry debug port.
// Programs the UART line control once after reset, then on each start strobe
// captures a snapshot and writes one hex line per channel into the UART THR.
// Every THR write waits for the empty flag, so no write is ever dropped.

`timescale 1ns/100ps

module hex_line_formatter (
    input  logic                                 clk,
    input  logic                                 resetn,
    input  logic                                 start_i,
    input  logic                                 thr_empty_i,
    input  logic [telemetry_pkg::word_w-1:0]     chan_word_i,
    output logic                                 capture_o,
    output logic [telemetry_pkg::chan_idx_w-1:0] chan_sel_o,
    output logic                                 reg_wr_o,
    output uart_pkg::uart_reg_e                  reg_addr_o,
    output logic [7:0]                           reg_wdata_o,
    output logic                                 busy_o,
    output logic                                 frame_done_o
);

    import telemetry_pkg::*;
    import uart_pkg::*;

    fmt_state_e            state_q;
    logic [chan_idx_w-1:0] chan_q;
    logic [char_idx_w-1:0] char_q;
    logic                  reg_wr_q;
    logic                  frame_done_q;
    uart_reg_e             reg_addr_q;
    logic [7:0]            reg_wdata_q;

    logic [7:0]            idx_byte;
    logic [char_idx_w-1:0] val_digit;
    logic [word_w-1:0]     val_shift;
    logic [7:0]            char_byte;
    logic                  last_char;
    logic                  last_chan;

    function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
        if (nib < 4'd10) begin
            return ascii_zero + 8'(nib);
        end
        return ascii_upper_a + 8'(nib - 4'd10);
    endfunction

    assign last_char = (char_q == char_idx_w'(chars_per_line - 1));
    assign last_chan = (chan_q == chan_idx_w'(num_channels - 1));

    // character for the current position in the line
    always_comb begin
        idx_byte  = 8'(chan_q);
        val_digit = char_q - char_pos_val;
        val_shift = chan_word_i << {val_digit[1:0], 2'b00};  // msb nibble first
        case (char_q)
            char_pos_idx_hi: char_byte = hex_ascii(idx_byte[7:4]);
            char_pos_idx_lo: char_byte = hex_ascii(idx_byte[3:0]);
            char_pos_lf:     char_byte = ascii_lf;
            char_pos_cr:     char_byte = ascii_cr;
            default:         char_byte = hex_ascii(val_shift[word_w-1 -: 4]);
        endcase
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q      <= FMT_INIT_LCR;
            chan_q       <= '0;
            char_q       <= '0;
            reg_wr_q     <= 1'b0;
            frame_done_q <= 1'b0;
        end else begin
            reg_wr_q     <= 1'b0;
            frame_done_q <= 1'b0;
            case (state_q)
                FMT_INIT_LCR: begin
                    reg_wr_q <= 1'b1;  // lcr write
                    state_q  <= FMT_IDLE;
                end
                FMT_IDLE: begin
                    if (start_i) begin
                        chan_q  <= '0;
                        char_q  <= '0;
                        state_q <= FMT_CAPTURE;
                    end
                end
                FMT_CAPTURE: state_q <= FMT_WAIT_EMPTY;
                FMT_WAIT_EMPTY: begin
                    if (thr_empty_i) begin
                        reg_wr_q <= 1'b1;
                        state_q  <= FMT_WRITE;
                    end
                end
                FMT_WRITE: state_q <= FMT_NEXT;  // uart latches the byte here
                FMT_NEXT: begin
                    char_q  <= last_char ? '0 : char_q + 1'b1;
                    state_q <= FMT_WAIT_EMPTY;
                    if (last_char) begin
                        chan_q <= chan_q + 1'b1;
                        if (last_chan) begin
                            state_q <= FMT_DONE;
                        end
                    end
                end
                FMT_DONE: begin
                    // hold busy until the last stop bit is out
                    if (thr_empty_i) begin
                        frame_done_q <= 1'b1;
                        state_q      <= FMT_IDLE;
                    end
                end
                default: state_q <= FMT_INIT_LCR;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == FMT_INIT_LCR) begin
            reg_addr_q  <= REG_LCR;
            reg_wdata_q <= lcr_init;
        end else if (state_q == FMT_WAIT_EMPTY && thr_empty_i) begin
            reg_addr_q  <= REG_THR;
            reg_wdata_q <= char_byte;
        end
    end

    assign capture_o    = (state_q == FMT_CAPTURE);
    assign chan_sel_o   = chan_q;
    assign reg_wr_o     = reg_wr_q;
    assign reg_addr_o   = reg_addr_q;
    assign reg_wdata_o  = reg_wdata_q;
    assign busy_o       = (state_q != FMT_IDLE) && (state_q != FMT_INIT_LCR);
    assign frame_done_o = frame_done_q;

endmodule

// File: verilog/uart_tx_engine.sv
// Transmit-only UART with a line control register and one holding register.
// A THR write is sent as 8N1, LSB first, one bit every clks_per_bit clocks.
// thr_empty_o stays low from the write until the stop bit has ended.

`timescale 1ns/100ps

module uart_tx_engine #(
    parameter int clks_per_bit = uart_pkg::default_clks_per_bit
) (
    input  logic                clk,
    input  logic                resetn,
    input  logic                reg_wr_i,
    input  uart_pkg::uart_reg_e reg_addr_i,
    input  logic [7:0]          reg_wdata_i,
    output logic                thr_empty_o,
    output logic                sout_o
);

    import uart_pkg::*;

    localparam int timer_w    = $clog2(clks_per_bit + 1);
    localparam int frame_bits = 10;  // start, 8 data, stop

    logic               tx_en_q;
    logic [7:0]         thr_q;
    logic               thr_full_q;
    logic               active_q;
    logic [8:0]         shift_q;
    logic [3:0]         bit_cnt_q;
    logic [timer_w-1:0] timer_q;
    logic               sout_q;
    logic               thr_wr;
    logic               tx_start;
    logic               bit_end;

    // writes to a full or disabled THR are dropped
    assign thr_wr   = reg_wr_i && (reg_addr_i == REG_THR) && tx_en_q && !thr_full_q;
    assign tx_start = thr_full_q && !active_q;
    assign bit_end  = active_q && (timer_q == timer_w'(clks_per_bit - 1));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            tx_en_q <= 1'b0;
        end else if (reg_wr_i && reg_addr_i == REG_LCR) begin
            tx_en_q <= reg_wdata_i[lcr_tx_en_bit];
        end
    end

    always_ff @(posedge clk) begin
        if (thr_wr) begin
            thr_q <= reg_wdata_i;
        end
        if (tx_start) begin
            shift_q <= {1'b1, thr_q};  // data then stop bit
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[8:1]};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            thr_full_q <= 1'b0;
            active_q   <= 1'b0;
            bit_cnt_q  <= '0;
            timer_q    <= '0;
            sout_q     <= 1'b1;  // idle line
        end else begin
            if (thr_wr) begin
                thr_full_q <= 1'b1;
            end
            if (tx_start) begin
                active_q  <= 1'b1;
                bit_cnt_q <= '0;
                timer_q   <= '0;
                sout_q    <= 1'b0;  // start bit
            end else if (active_q) begin
                timer_q <= bit_end ? '0 : timer_q + 1'b1;
                if (bit_end) begin
                    if (bit_cnt_q == 4'(frame_bits - 1)) begin
                        active_q   <= 1'b0;
                        thr_full_q <= 1'b0;
                    end else begin
                        sout_q    <= shift_q[0];
                        bit_cnt_q <= bit_cnt_q + 1'b1;
                    end
                end
            end
        end
    end

    assign thr_empty_o = !thr_full_q;
    assign sout_o      = sout_q;

endmodule

// File: verilog/telemetry_uart_top.sv
// Telemetry debug port top level.
// start_i snapshots chan_data_i and sends it as eight hex lines on sout_o;
// frame_done_o pulses once the last character has left the line.

`timescale 1ns/100ps

module telemetry_uart_top (
    input  logic                     clk,
    input  logic                     resetn,
    input  logic                     start_i,
    input  telemetry_pkg::chan_bus_t chan_data_i,
    output logic                     sout_o,
    output logic                     busy_o,
    output logic                     frame_done_o
);

    import telemetry_pkg::*;
    import uart_pkg::*;

    logic                  capture;
    logic [chan_idx_w-1:0] chan_sel;
    logic [word_w-1:0]     chan_word;
    logic                  reg_wr;
    uart_reg_e             reg_addr;
    logic [7:0]            reg_wdata;
    logic                  thr_empty;

    telemetry_snapshot i_snapshot (
        .clk         (clk),
        .resetn      (resetn),
        .capture_i   (capture),
        .chan_data_i (chan_data_i),
        .chan_sel_i  (chan_sel),
        .chan_word_o (chan_word)
    );

    hex_line_formatter i_formatter (
        .clk          (clk),
        .resetn       (resetn),
        .start_i      (start_i),
        .thr_empty_i  (thr_empty),
        .chan_word_i  (chan_word),
        .capture_o    (capture),
        .chan_sel_o   (chan_sel),
        .reg_wr_o     (reg_wr),
        .reg_addr_o   (reg_addr),
        .reg_wdata_o  (reg_wdata),
        .busy_o       (busy_o),
        .frame_done_o (frame_done_o)
    );

    uart_tx_engine i_uart (
        .clk         (clk),
        .resetn      (resetn),
        .reg_wr_i    (reg_wr),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .thr_empty_o (thr_empty),
        .sout_o      (sout_o)
    );

endmodule

// File: test/telemetry_uart_sva.sv
// Protocol assertions for the telemetry debug port.
// Bound to the top level; watches the formatter to UART register bus
// and the frame status outputs.

`timescale 1ns/100ps

module telemetry_uart_sva (
    input logic                clk,
    input logic                resetn,
    input logic                reg_wr_i,
    input uart_pkg::uart_reg_e reg_addr_i,
    input logic                thr_empty_i,
    input logic                sout_i,
    input logic                busy_i,
    input logic                frame_done_i
);

    import uart_pkg::*;

    int unsigned fail_count = 0;  // read by the testbench at the end

    // a THR write into a full holding register would be lost
    a_thr_write_empty: assert property (
        @(posedge clk) disable iff (!resetn)
        (reg_wr_i && reg_addr_i == REG_THR) |-> thr_empty_i
    ) else begin
        $error("THR written while the holding register is full");
        fail_count++;
    end

    a_done_drops_busy: assert property (
        @(posedge clk) disable iff (!resetn)
        frame_done_i |-> (!busy_i && $past(busy_i))
    ) else begin
        $error("frame_done_o without busy_o falling");
        fail_count++;
    end

    // idle line between frames
    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!resetn)
        !busy_i |-> sout_i
    ) else begin
        $error("sout_o low while not busy");
        fail_count++;
    end

endmodule

// File: test/telemetry_uart_tb.sv
// Directed testbench for the telemetry debug port.
// Decodes sout_o as 8N1 serial at mid-bit and compares each frame with
// a model built from the channel values; assertions are bound to the DUT.

`timescale 1ns/100ps

module telemetry_uart_tb;

    import telemetry_pkg::*;

    localparam int bit_clks     = uart_pkg::default_clks_per_bit;
    localparam int frame_chars  = num_channels * chars_per_line;
    localparam int char_timeout = 1000;  // cycles until the next start bit
    localparam int done_timeout = 500;

    logic      clk;
    logic      resetn;
    logic      start_i;
    chan_bus_t chan_data_i;
    logic      sout_o;
    logic      busy_o;
    logic      frame_done_o;

    logic [7:0] rx_bytes  [frame_chars];
    logic [7:0] exp_bytes [frame_chars];
    int         rx_count;
    logic       rx_done;
    logic       timed_out;
    int         error_count;
    int         check_count;
    int         done_count;

    telemetry_uart_top i_dut (
        .clk          (clk),
        .resetn       (resetn),
        .start_i      (start_i),
        .chan_data_i  (chan_data_i),
        .sout_o       (sout_o),
        .busy_o       (busy_o),
        .frame_done_o (frame_done_o)
    );

    bind telemetry_uart_top telemetry_uart_sva i_sva (
        .clk          (clk),
        .resetn       (resetn),
        .reg_wr_i     (reg_wr),
        .reg_addr_i   (reg_addr),
        .thr_empty_i  (thr_empty),
        .sout_i       (sout_o),
        .busy_i       (busy_o),
        .frame_done_i (frame_done_o)
    );

    always #5 clk = ~clk;

    always @(negedge clk) begin
        if (frame_done_o) begin
            done_count++;
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    function automatic logic [7:0] hex_digit(input int nib);
        string digits;
        digits = "0123456789ABCDEF";
        return digits[nib];
    endfunction

    // expected line per channel: index, value msb first, LF, CR
    function automatic void build_frame(input chan_bus_t vals);
        int          base;
        logic [15:0] w;
        for (int c = 0; c < num_channels; c++) begin
            base = c * chars_per_line;
            w    = vals[c];
            exp_bytes[base]     = hex_digit(c / 16);
            exp_bytes[base + 1] = hex_digit(c % 16);
            exp_bytes[base + 2] = hex_digit(int'(w[15:12]));
            exp_bytes[base + 3] = hex_digit(int'(w[11:8]));
            exp_bytes[base + 4] = hex_digit(int'(w[7:4]));
            exp_bytes[base + 5] = hex_digit(int'(w[3:0]));
            exp_bytes[base + 6] = ascii_lf;
            exp_bytes[base + 7] = ascii_cr;
        end
    endfunction

    function automatic chan_bus_t rand_bus();
        chan_bus_t v;
        for (int c = 0; c < num_channels; c++) begin
            v[c] = word_w'($urandom);
        end
        return v;
    endfunction

    // one 8N1 character, sampled at negedge near mid-bit
    task automatic decode_byte(output logic [7:0] data);
        int waited;
        waited = 0;
        data   = '0;
        @(negedge clk);
        while (sout_o !== 1'b0 && waited < char_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (sout_o !== 1'b0) begin
            $display("Timeout: no start bit on sout_o within %0d cycles", char_timeout);
            error_count++;
            timed_out = 1'b1;
            return;
        end
        repeat (bit_clks / 2 - 1) @(negedge clk);
        if (sout_o !== 1'b0) begin
            $display("Start bit on sout_o ended early");
            error_count++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (bit_clks) @(negedge clk);
            data[i] = sout_o;  // lsb first
        end
        repeat (bit_clks) @(negedge clk);
        if (sout_o !== 1'b1) begin
            $display("Framing error, stop bit low on sout_o");
            error_count++;
        end
    endtask

    task automatic receive_frame();
        logic [7:0] b;
        rx_count  = 0;
        rx_done   = 1'b0;
        timed_out = 1'b0;
        while (rx_count < frame_chars && !timed_out) begin
            decode_byte(b);
            if (!timed_out) begin
                rx_bytes[rx_count] = b;
                rx_count++;
            end
        end
        rx_done = 1'b1;
    endtask

    task automatic wait_frame_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!frame_done_o && waited < done_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (!frame_done_o) begin
            $display("Timeout: frame_done_o never pulsed after the last character");
            error_count++;
        end
        @(negedge clk);  // step past the done pulse
    endtask

    task automatic send_start(input chan_bus_t vals);
        @(posedge clk);
        #1;
        chan_data_i = vals;
        start_i     = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
    endtask

    task automatic compare_frame(input string name, input chan_bus_t vals);
        build_frame(vals);
        check(name, frame_chars, rx_count);
        for (int i = 0; i < rx_count; i++) begin
            check(name, 32'(exp_bytes[i]), 32'(rx_bytes[i]));
        end
    endtask

    task automatic test_reset_state();
        repeat (20) begin
            @(negedge clk);
            check("reset_state", 32'(1'b1), 32'(sout_o));
            check("reset_state", 32'(1'b0), 32'(busy_o));
            check("reset_state", 32'(1'b0), 32'(frame_done_o));
        end
    endtask

    task automatic test_fixed_frame();
        chan_bus_t vals;
        int        done_before;
        vals = {16'h5A6B, 16'h9C3D, 16'h7E81, 16'hBEEF,
                16'h0000, 16'hFFFF, 16'h1234, 16'hA5F0};
        done_before = done_count;
        send_start(vals);
        receive_frame();
        wait_frame_done();
        compare_frame("fixed_frame", vals);
        check("fixed_frame", done_before + 1, done_count);
    endtask

    task automatic test_snapshot_hold();
        chan_bus_t vals;
        vals = rand_bus();
        send_start(vals);
        fork
            receive_frame();
            do begin
                @(posedge clk);
                #1;
                chan_data_i = rand_bus();  // after the capture edge
            end while (!rx_done);
        join
        wait_frame_done();
        compare_frame("snapshot_hold", vals);
    endtask

    task automatic test_start_ignored();
        chan_bus_t vals;
        int        done_before;
        int        bad_cycles;
        vals        = {16'h0F1E, 16'h2D3C, 16'h4B5A, 16'h6978,
                       16'h8796, 16'hA5B4, 16'hC3D2, 16'hE1F0};
        done_before = done_count;
        bad_cycles  = 0;
        send_start(vals);
        fork
            receive_frame();
            for (int k = 0; k < 4; k++) begin
                repeat (400) @(posedge clk);
                #1;
                start_i = 1'b1;
                @(posedge clk);
                #1;
                start_i = 1'b0;
            end
        join
        wait_frame_done();
        compare_frame("start_ignored", vals);
        repeat (200) begin
            @(negedge clk);
            if (sout_o !== 1'b1 || busy_o !== 1'b0) begin
                bad_cycles++;
            end
        end
        check("start_ignored", 0, bad_cycles);
        check("start_ignored", done_before + 1, done_count);
    endtask

    task automatic test_back_to_back();
        chan_bus_t vals;
        for (int f = 0; f < 3; f++) begin
            vals = rand_bus();
            send_start(vals);  // right after the previous frame_done_o
            receive_frame();
            wait_frame_done();
            compare_frame("back_to_back", vals);
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        start_i     = 1'b0;
        chan_data_i = '0;
        error_count = 0;
        check_count = 0;
        done_count  = 0;
        rx_count    = 0;
        rx_done     = 1'b0;
        timed_out   = 1'b0;
        void'($urandom(32'h4fa977dc));
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        test_reset_state();
        test_fixed_frame();
        test_snapshot_hold();
        test_start_ignored();
        test_back_to_back();

        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, i_dut.i_sva.fail_count);
        if (error_count == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: telemetry_uart.f
verilog/telemetry_pkg.sv
verilog/uart_pkg.sv
verilog/telemetry_snapshot.sv
verilog/hex_line_formatter.sv
verilog/uart_tx_engine.sv
verilog/telemetry_uart_top.sv
test/telemetry_uart_sva.sv
test/telemetry_uart_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the telemetry debug port testbench with Verilator and run it.
set -e

cd "$(dirname "$0")"

LOG=sim.log
SIM=telemetry_uart_sim

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
    -f telemetry_uart.f --top-module telemetry_uart_tb -o "$SIM"

sim_status=0
./obj_dir/"$SIM" +verilator+error+limit+100 > "$LOG" 2>&1 || sim_status=$?
cat "$LOG"

if [ "$sim_status" -eq 0 ] && grep -q "All tests passed" "$LOG"; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
